//--- logic/mvd_macros.svh
`ifndef MVD_MACROS_SVH
`define MVD_MACROS_SVH

// ========================================
// image geometry
// ========================================

// square reference image, pixels per side
`define MVD_IMG_DIM 16
// square matching block, pixels per side
`define MVD_BLK_DIM 8
`define MVD_PIX_W 8
// L0 and L1
`define MVD_NUM_IMG 2

// one request is L0 x, L0 y, L1 x, L1 y
`define MVD_MV_BEATS 4

`endif

//--- logic/mvdPkg.sv
`default_nettype none

`include "mvd_macros.svh"

package mvdPkg;

    typedef logic [`MVD_PIX_W-1:0] pixel_t;

    // a whole image row, column 0 in the low byte
    typedef logic [`MVD_IMG_DIM*`MVD_PIX_W-1:0] rowWord_t;

    typedef logic [$clog2(`MVD_IMG_DIM)-1:0] coord_t;

    // image select on top, row below
    typedef logic [$clog2(`MVD_NUM_IMG)+$clog2(`MVD_IMG_DIM)-1:0] rowAddr_t;

    // eight block pixels, block column 0 in the low byte
    typedef logic [`MVD_BLK_DIM*`MVD_PIX_W-1:0] blockRow_t;

    // worst case is every pixel differing by full scale
    typedef logic [$clog2(`MVD_BLK_DIM*`MVD_BLK_DIM*((1<<`MVD_PIX_W)-1)+1)-1:0] sad_t;

    typedef enum logic [1:0] {IDLE, FETCH, DRAIN} fetchState_t;

endpackage

`default_nettype wire

//--- logic/imageBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvd_macros.svh"

module imageBuffer (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   inValid,
    input  wire mvdPkg::pixel_t   inData,
    input  wire                   rdEn,
    input  wire mvdPkg::rowAddr_t rdAddr,
    output mvdPkg::rowWord_t      rdRow
);
    import mvdPkg::*;

    localparam int colW = $clog2(`MVD_IMG_DIM);
    localparam int loadCntW = $bits(rowAddr_t) + colW;
    localparam int depth = 2 ** $bits(rowAddr_t);

    logic [loadCntW-1:0] loadCnt;
    rowWord_t            rowAsm;
    rowWord_t            rowNext;
    logic                rowEnd;
    rowWord_t            mem [0:depth-1];

    // raster position of the next pixel, wraps after both images
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            loadCnt <= '0;
        end else if (inValid) begin
            loadCnt <= loadCnt + 1'b1;
        end
    end

    // newest pixel enters at the top, so column 0 ends up in the low byte
    assign rowNext = {inData, rowAsm[$bits(rowWord_t)-1:`MVD_PIX_W]};
    assign rowEnd = inValid && (&loadCnt[colW-1:0]);

    always_ff @(posedge clk) begin
        if (inValid) begin
            rowAsm <= rowNext;
        end
    end

    // ========================================
    // row memory, one cycle read latency
    // ========================================
    always_ff @(posedge clk) begin
        if (rowEnd) begin
            mem[loadCnt[loadCntW-1:colW]] <= rowNext;
        end
        if (rdEn) begin
            rdRow <= mem[rdAddr];
        end
    end

endmodule

`default_nettype wire

//--- logic/mvCapture.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvd_macros.svh"

module mvCapture (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 inValid2,
    input  wire mvdPkg::coord_t inCoord,
    output logic                mvReady,
    output mvdPkg::coord_t      l0X,
    output mvdPkg::coord_t      l0Y,
    output mvdPkg::coord_t      l1X,
    output mvdPkg::coord_t      l1Y
);
    import mvdPkg::*;

    localparam int beatW = $clog2(`MVD_MV_BEATS);

    logic [beatW-1:0] beatCnt;
    logic             lastBeat;

    assign lastBeat = inValid2 && (beatCnt == beatW'(`MVD_MV_BEATS - 1));

    // counter wraps on its own after the last beat
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beatCnt <= '0;
            mvReady <= 1'b0;
        end else begin
            mvReady <= lastBeat;
            if (inValid2) begin
                beatCnt <= beatCnt + 1'b1;
            end
        end
    end

    // steer beat into its origin
    always_ff @(posedge clk) begin
        if (inValid2) begin
            case (beatCnt)
                2'd0:    l0X <= inCoord;
                2'd1:    l0Y <= inCoord;
                2'd2:    l1X <= inCoord;
                default: l1Y <= inCoord;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- logic/blockFetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvd_macros.svh"

module blockFetch (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   mvReady,
    input  wire mvdPkg::coord_t   l0X,
    input  wire mvdPkg::coord_t   l0Y,
    input  wire mvdPkg::coord_t   l1X,
    input  wire mvdPkg::coord_t   l1Y,
    output logic                  rdEn,
    output mvdPkg::rowAddr_t      rdAddr,
    input  wire mvdPkg::rowWord_t rdRow,
    output logic                  rowValid,
    output logic                  rowIsL1,
    output mvdPkg::blockRow_t     rowPix
);
    import mvdPkg::*;

    localparam int idxW = $clog2(`MVD_BLK_DIM);
    localparam int cntW = idxW + 1;
    localparam logic [cntW-1:0] lastRead = cntW'(2 * `MVD_BLK_DIM - 1);
    localparam coord_t maxCoord = coord_t'(`MVD_IMG_DIM - 1);

    fetchState_t     state;
    logic [cntW-1:0] readCnt;
    logic            readIsL1;
    logic [idxW-1:0] readRow;
    coord_t          originX;
    coord_t          originY;
    coord_t          xD;

    // origin plus offset, held at the last pixel of the image
    function automatic coord_t clampAdd(input coord_t base, input logic [idxW-1:0] offset);
        logic [$bits(coord_t):0] total;
        total = base + offset;
        return (total > maxCoord) ? maxCoord : coord_t'(total);
    endfunction

    // ========================================
    // read sequencer
    // ========================================

    // first read goes out in the mvReady cycle itself
    assign rdEn = (state == FETCH) || (state == IDLE && mvReady);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            readCnt <= '0;
        end else begin
            if (rdEn) begin
                readCnt <= readCnt + 1'b1;
            end
            case (state)
                IDLE:    if (mvReady) state <= FETCH;
                FETCH:   if (readCnt == lastRead) state <= DRAIN;
                // last row still on its way back
                DRAIN:   state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // even reads are L0, odd reads L1 of the same block row
    assign readIsL1 = readCnt[0];
    assign readRow = readCnt[cntW-1:1];
    assign originX = readIsL1 ? l1X : l0X;
    assign originY = readIsL1 ? l1Y : l0Y;
    assign rdAddr = {readIsL1, clampAdd(originY, readRow)};

    // ========================================
    // column select on returned word
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rowValid <= 1'b0;
            rowIsL1  <= 1'b0;
        end else begin
            rowValid <= rdEn;
            rowIsL1  <= readIsL1;
        end
    end

    // x origin travels alongside the read
    always_ff @(posedge clk) begin
        if (rdEn) begin
            xD <= originX;
        end
    end

    // clamped columns replicate the right edge pixel
    for (genvar i = 0; i < `MVD_BLK_DIM; i++) begin : gPix
        coord_t col;
        assign col = clampAdd(xD, idxW'(i));
        assign rowPix[i*`MVD_PIX_W +: `MVD_PIX_W] = rdRow[col*`MVD_PIX_W +: `MVD_PIX_W];
    end

endmodule

`default_nettype wire

//--- logic/sadAccum.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvd_macros.svh"

module sadAccum (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    rowValid,
    input  wire                    rowIsL1,
    input  wire mvdPkg::blockRow_t rowPix,
    output logic                   outValid,
    output mvdPkg::sad_t           outSad
);
    import mvdPkg::*;

    blockRow_t                       l0Row;
    sad_t                            runSum;
    sad_t                            pairSad;
    logic [$clog2(`MVD_BLK_DIM)-1:0] pairCnt;
    logic                            pairIn;
    logic                            lastPair;

    // sum of |a - b| over one row pair
    function automatic sad_t rowSad(input blockRow_t a, input blockRow_t b);
        sad_t   acc;
        pixel_t pa;
        pixel_t pb;
        acc = '0;
        for (int i = 0; i < `MVD_BLK_DIM; i++) begin
            pa = a[i*`MVD_PIX_W +: `MVD_PIX_W];
            pb = b[i*`MVD_PIX_W +: `MVD_PIX_W];
            acc = acc + ((pa > pb) ? sad_t'(pa - pb) : sad_t'(pb - pa));
        end
        return acc;
    endfunction

    assign pairIn = rowValid && rowIsL1;
    assign pairSad = rowSad(l0Row, rowPix);

    // L0 row waits one cycle for its L1 partner
    always_ff @(posedge clk) begin
        if (rowValid && !rowIsL1) begin
            l0Row <= rowPix;
        end
        if (lastPair) begin
            outSad <= runSum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            runSum   <= '0;
            pairCnt  <= '0;
            lastPair <= 1'b0;
            outValid <= 1'b0;
        end else begin
            lastPair <= pairIn && (&pairCnt);
            outValid <= lastPair;
            // clear once the block result is taken
            if (lastPair) begin
                runSum <= '0;
            end else if (pairIn) begin
                runSum  <= runSum + pairSad;
                pairCnt <= pairCnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/mvdTop.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvd_macros.svh"

module mvdTop (
    input  wire                 clk,
    input  wire                 rst_n,
    input  wire                 inValid,
    input  wire mvdPkg::pixel_t inData,
    input  wire                 inValid2,
    input  wire mvdPkg::coord_t inCoord,
    output logic                outValid,
    output mvdPkg::sad_t        outSad
);

    logic              rdEn;
    mvdPkg::rowAddr_t  rdAddr;
    mvdPkg::rowWord_t  rdRow;
    logic              mvReady;
    mvdPkg::coord_t    l0X;
    mvdPkg::coord_t    l0Y;
    mvdPkg::coord_t    l1X;
    mvdPkg::coord_t    l1Y;
    logic              rowValid;
    logic              rowIsL1;
    mvdPkg::blockRow_t rowPix;

    // ========================================
    // image store and request capture
    // ========================================
    imageBuffer uImageBuffer (
        .clk     (clk),
        .rst_n   (rst_n),
        .inValid (inValid),
        .inData  (inData),
        .rdEn    (rdEn),
        .rdAddr  (rdAddr),
        .rdRow   (rdRow)
    );

    mvCapture uMvCapture (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid2 (inValid2),
        .inCoord  (inCoord),
        .mvReady  (mvReady),
        .l0X      (l0X),
        .l0Y      (l0Y),
        .l1X      (l1X),
        .l1Y      (l1Y)
    );

    // ========================================
    // block fetch and SAD
    // ========================================
    blockFetch uBlockFetch (
        .clk      (clk),
        .rst_n    (rst_n),
        .mvReady  (mvReady),
        .l0X      (l0X),
        .l0Y      (l0Y),
        .l1X      (l1X),
        .l1Y      (l1Y),
        .rdEn     (rdEn),
        .rdAddr   (rdAddr),
        .rdRow    (rdRow),
        .rowValid (rowValid),
        .rowIsL1  (rowIsL1),
        .rowPix   (rowPix)
    );

    sadAccum uSadAccum (
        .clk      (clk),
        .rst_n    (rst_n),
        .rowValid (rowValid),
        .rowIsL1  (rowIsL1),
        .rowPix   (rowPix),
        .outValid (outValid),
        .outSad   (outSad)
    );

endmodule

`default_nettype wire

//--- dv/mvd_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvd_macros.svh"

module mvdProperties (
    input wire clk,
    input wire rst_n,
    input wire inValid,
    input wire inValid2,
    input wire outValid
);

    localparam int beatW = $clog2(`MVD_MV_BEATS);
    // fourth beat edge to the edge that samples outValid
    localparam int latency = 19;

    logic [beatW-1:0] beatCnt;
    int               assertFails = 0;

    // own count of request beats
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beatCnt <= '0;
        end else if (inValid2) begin
            beatCnt <= beatCnt + 1'b1;
        end
    end

    outValidPulse: assert property (@(posedge clk) disable iff (!rst_n)
        outValid |=> !outValid)
        else begin
            assertFails++;
            $error("outValid stayed high for two cycles");
        end

    streamsApart: assert property (@(posedge clk) disable iff (!rst_n)
        !(inValid && inValid2))
        else begin
            assertFails++;
            $error("inValid and inValid2 high in the same cycle");
        end

    fixedLatency: assert property (@(posedge clk) disable iff (!rst_n)
        (inValid2 && beatCnt == beatW'(`MVD_MV_BEATS - 1)) |-> ##latency outValid)
        else begin
            assertFails++;
            $error("outValid missing 19 cycles after the last request beat");
        end

endmodule

bind mvdTop mvdProperties uProps (
    .clk      (clk),
    .rst_n    (rst_n),
    .inValid  (inValid),
    .inValid2 (inValid2),
    .outValid (outValid)
);

`default_nettype wire

//--- dv/mvdChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvd_macros.svh"

module mvdChecker (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               outValid,
    input  wire mvdPkg::sad_t outSad,
    input  wire               expValid,
    input  wire mvdPkg::sad_t expSad,
    output int                passCount,
    output int                failCount
);
    import mvdPkg::*;

    sad_t expQ[$];
    sad_t expNow;
    int   testNum;

    initial begin
        passCount = 0;
        failCount = 0;
        testNum   = 0;
    end

    // ========================================
    // compare each result with its request
    // ========================================
    always @(posedge clk) begin
        if (rst_n && expValid) begin
            expQ.push_back(expSad);
        end
        if (rst_n && outValid) begin
            testNum = testNum + 1;
            if (expQ.size() == 0) begin
                $display("test %0d: result 0x%h arrived with no request pending",
                         testNum, outSad);
                failCount <= failCount + 1;
            end else begin
                expNow = expQ.pop_front();
                if (outSad === expNow) begin
                    $display("Pass test %0d outSad 0x%h", testNum, outSad);
                    passCount <= passCount + 1;
                end else begin
                    $display("Fail test %0d outSad expected 0x%h actual 0x%h",
                             testNum, expNow, outSad);
                    failCount <= failCount + 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/mvdTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mvd_macros.svh"

module mvdTb;
    import mvdPkg::*;

    localparam string stimPath = "dv/mvd_stim.txt";
    localparam int loadBeats = `MVD_NUM_IMG * `MVD_IMG_DIM * `MVD_IMG_DIM;

    logic   clk;
    logic   rst_n;
    logic   inValid;
    pixel_t inData;
    logic   inValid2;
    coord_t inCoord;
    logic   outValid;
    sad_t   outSad;
    logic   expValid;
    sad_t   expSad;
    int     passCount;
    int     failCount;
    int     failTotal;
    int     cycleCnt = 0;
    int     cycleLimit = 0;

    // one entry per stim line
    coord_t l0xQ[$];
    coord_t l0yQ[$];
    coord_t l1xQ[$];
    coord_t l1yQ[$];
    sad_t   sadQ[$];

    mvdTop DUT (
        .clk      (clk),
        .rst_n    (rst_n),
        .inValid  (inValid),
        .inData   (inData),
        .inValid2 (inValid2),
        .inCoord  (inCoord),
        .outValid (outValid),
        .outSad   (outSad)
    );

    mvdChecker uChecker (
        .clk       (clk),
        .rst_n     (rst_n),
        .outValid  (outValid),
        .outSad    (outSad),
        .expValid  (expValid),
        .expSad    (expSad),
        .passCount (passCount),
        .failCount (failCount)
    );

    always #5 clk = ~clk;

    // pixel at image m, row r, column c
    function automatic pixel_t pixelRule(input int m, input int r, input int c);
        return pixel_t'(((r * `MVD_IMG_DIM + c) * 3 + m * 41) % 256);
    endfunction

    task automatic readStim();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f0;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        fd = $fopen(stimPath, "r");
        if (fd == 0) begin
            $display("cannot open stimulus file %s, no tests to run", stimPath);
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                    if (n == 5) begin
                        l0xQ.push_back(coord_t'(f0));
                        l0yQ.push_back(coord_t'(f1));
                        l1xQ.push_back(coord_t'(f2));
                        l1yQ.push_back(coord_t'(f3));
                        sadQ.push_back(sad_t'(f4));
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // raster order with the L0 image first
    task automatic loadImages();
        for (int m = 0; m < `MVD_NUM_IMG; m++) begin
            for (int r = 0; r < `MVD_IMG_DIM; r++) begin
                for (int c = 0; c < `MVD_IMG_DIM; c++) begin
                    @(posedge clk);
                    inValid <= 1'b1;
                    inData  <= pixelRule(m, r, c);
                end
            end
        end
        @(posedge clk);
        inValid <= 1'b0;
    endtask

    // ========================================
    // send one request and wait for its result
    // ========================================
    task automatic runRequest(input int idx);
        @(posedge clk);
        expValid <= 1'b1;
        expSad   <= sadQ[idx];
        inValid2 <= 1'b1;
        inCoord  <= l0xQ[idx];
        @(posedge clk);
        expValid <= 1'b0;
        inCoord  <= l0yQ[idx];
        @(posedge clk);
        inCoord  <= l1xQ[idx];
        @(posedge clk);
        inCoord  <= l1yQ[idx];
        @(posedge clk);
        inValid2 <= 1'b0;
        while (!outValid) begin
            @(posedge clk);
        end
    endtask

    initial begin : watchdog
        wait (cycleLimit > 0);
        while (cycleCnt < cycleLimit) begin
            @(posedge clk);
            cycleCnt++;
        end
        $display("run timed out after %0d cycles before all results arrived", cycleCnt);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk      = 1'b0;
        rst_n    = 1'b0;
        inValid  = 1'b0;
        inData   = '0;
        inValid2 = 1'b0;
        inCoord  = '0;
        expValid = 1'b0;
        expSad   = '0;
        readStim();
        cycleLimit = loadBeats + sadQ.size() * 30 + 50;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        loadImages();
        for (int i = 0; i < sadQ.size(); i++) begin
            runRequest(i);
        end
        repeat (3) @(posedge clk);
        failTotal = failCount + DUT.uProps.assertFails;
        $display("passed %0d failed %0d", passCount, failTotal);
        if (failTotal == 0 && passCount == sadQ.size() && passCount > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/mvd_stim.txt
# columns, all hex: l0x l0y l1x l1y expectedSad
# pixel(m, r, c) = ((16 * r + c) * 3 + 41 * m) mod 256, block edges clamped to 15
0 0 0 0 0e54
0 0 2 1 1be0
4 4 4 4 1316
3 2 1 4 1fe8
c a 9 e 285e
f f f f 35c0
a 0 2 9 19e0
0 0 0 0 0e54

//--- vlog.f
+incdir+logic
logic/mvdPkg.sv
logic/imageBuffer.sv
logic/mvCapture.sv
logic/blockFetch.sv
logic/sadAccum.sv
logic/mvdTop.sv
dv/mvd_properties.sv
dv/mvdChecker.sv
dv/mvdTb.sv
